// File: la32_decode_pkg.sv
package la32_decode_pkg;

    typedef logic [31:0] insn_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [1:0]  iq_class_t;
    typedef logic [4:0]  alu0_op_t;
    typedef logic [2:0]  alu1_op_t;
    typedef logic [3:0]  bru_op_t;
    typedef logic [19:0] alu0_imm_t;
    typedef logic [25:0] bru_imm_t;
    typedef logic [1:0]  exc_cause_t;
    typedef logic [14:0] exc_code_t;

    localparam iq_class_t IQ_NONE = 2'd0;
    localparam iq_class_t IQ_ALU0 = 2'd1;
    localparam iq_class_t IQ_ALU1 = 2'd2;
    localparam iq_class_t IQ_BRU  = 2'd3;

    localparam alu0_op_t ALU0_LU12I   = 5'd0;
    localparam alu0_op_t ALU0_SLTI    = 5'd1;
    localparam alu0_op_t ALU0_SLTUI   = 5'd2;
    localparam alu0_op_t ALU0_ADDI    = 5'd3;
    localparam alu0_op_t ALU0_ANDI    = 5'd4;
    localparam alu0_op_t ALU0_ORI     = 5'd5;
    localparam alu0_op_t ALU0_XORI    = 5'd6;
    localparam alu0_op_t ALU0_ADD     = 5'd7;
    localparam alu0_op_t ALU0_SUB     = 5'd8;
    localparam alu0_op_t ALU0_SLT     = 5'd9;
    localparam alu0_op_t ALU0_SLTU    = 5'd10;
    localparam alu0_op_t ALU0_NOR     = 5'd11;
    localparam alu0_op_t ALU0_AND     = 5'd12;
    localparam alu0_op_t ALU0_OR      = 5'd13;
    localparam alu0_op_t ALU0_XOR     = 5'd14;
    localparam alu0_op_t ALU0_SLL     = 5'd15;
    localparam alu0_op_t ALU0_SRL     = 5'd16;
    localparam alu0_op_t ALU0_SRA     = 5'd17;
    localparam alu0_op_t ALU0_RDCNTVH = 5'd18;
    localparam alu0_op_t ALU0_RDCNTVL = 5'd19;
    localparam alu0_op_t ALU0_RDCNTID = 5'd20;
    localparam alu0_op_t ALU0_SLLI    = 5'd21;
    localparam alu0_op_t ALU0_SRLI    = 5'd22;
    localparam alu0_op_t ALU0_SRAI    = 5'd23;

    localparam alu1_op_t ALU1_DIV   = 3'd0;
    localparam alu1_op_t ALU1_MOD   = 3'd1;
    localparam alu1_op_t ALU1_DIVU  = 3'd2;
    localparam alu1_op_t ALU1_MODU  = 3'd3;
    localparam alu1_op_t ALU1_MUL   = 3'd4;
    localparam alu1_op_t ALU1_MULH  = 3'd5;
    localparam alu1_op_t ALU1_MULHU = 3'd6;

    localparam bru_op_t BRU_PCADDU12I = 4'd0;
    localparam bru_op_t BRU_JIRL      = 4'd1;
    localparam bru_op_t BRU_B         = 4'd2;
    localparam bru_op_t BRU_BL        = 4'd3;
    localparam bru_op_t BRU_BEQ       = 4'd4;
    localparam bru_op_t BRU_BNE       = 4'd5;
    localparam bru_op_t BRU_BLT       = 4'd6;
    localparam bru_op_t BRU_BGE       = 4'd7;
    localparam bru_op_t BRU_BLTU      = 4'd8;
    localparam bru_op_t BRU_BGEU      = 4'd9;

    localparam exc_cause_t EXC_NONE    = 2'd0;
    localparam exc_cause_t EXC_BREAK   = 2'd1;
    localparam exc_cause_t EXC_SYSCALL = 2'd2;
    localparam exc_cause_t EXC_ILLEGAL = 2'd3;

    localparam reg_idx_t LINK_REG = 5'd1;

endpackage

// File: insn_classifier.sv
`timescale 1ns/1ps

module insn_classifier (
    input  la32_decode_pkg::insn_t      insn,
    output la32_decode_pkg::iq_class_t  iq_class,
    output la32_decode_pkg::exc_cause_t exc_cause,
    output la32_decode_pkg::exc_code_t  exc_code
);

    logic is_break;
    logic is_syscall;
    logic is_rdcnt;

    assign is_break   = (insn[31:15] == 17'b00000000001010100);
    assign is_syscall = (insn[31:15] == 17'b00000000001010110);

    // RDCNTVL/RDCNTID share a minor opcode, RDCNTVH needs rj zero
    assign is_rdcnt = ((insn[14:10] == 5'b11000) && ((insn[9:5] == 5'd0) || (insn[4:0] == 5'd0)))
                   || ((insn[14:10] == 5'b11001) && (insn[9:5] == 5'd0));

    always_comb begin
        iq_class = la32_decode_pkg::IQ_NONE;
        case (insn[31:26])
            6'b000000: begin
                if (insn[25]) begin
                    if ((insn[24:22] != 3'b011) && (insn[24:22] != 3'b100))
                        iq_class = la32_decode_pkg::IQ_ALU0;    // SLTI..XORI
                end else if (insn[24:22] == 3'b001) begin
                    case (insn[21:15])
                        7'b0000001, 7'b0001001, 7'b0010001:
                            iq_class = la32_decode_pkg::IQ_ALU0; // Shift by immediate
                        default: ;
                    endcase
                end else if (insn[24:22] == 3'b000) begin
                    case (insn[21:15])
                        7'b0100000, 7'b0100010, 7'b0100100, 7'b0100101,
                        7'b0101000, 7'b0101001, 7'b0101010, 7'b0101011,
                        7'b0101110, 7'b0101111, 7'b0110000:
                            iq_class = la32_decode_pkg::IQ_ALU0;
                        7'b0111000, 7'b0111001, 7'b0111010,
                        7'b1000000, 7'b1000001, 7'b1000010, 7'b1000011:
                            iq_class = la32_decode_pkg::IQ_ALU1;
                        7'b0000000:
                            if (is_rdcnt)
                                iq_class = la32_decode_pkg::IQ_ALU0;
                        default: ;
                    endcase
                end
            end
            6'b000101: if (!insn[25]) iq_class = la32_decode_pkg::IQ_ALU0;    // LU12I.W
            6'b000111: if (!insn[25]) iq_class = la32_decode_pkg::IQ_BRU;     // PCADDU12I
            6'b010011, 6'b010100, 6'b010101, 6'b010110, 6'b010111,
            6'b011000, 6'b011001, 6'b011010, 6'b011011:
                iq_class = la32_decode_pkg::IQ_BRU;
            default: ;
        endcase
    end

    always_comb begin
        exc_cause = la32_decode_pkg::EXC_NONE;
        exc_code  = '0;
        if (is_break) begin
            exc_cause = la32_decode_pkg::EXC_BREAK;
            exc_code  = insn[14:0];
        end else if (is_syscall) begin
            exc_cause = la32_decode_pkg::EXC_SYSCALL;
            exc_code  = insn[14:0];
        end else if (iq_class == la32_decode_pkg::IQ_NONE) begin
            exc_cause = la32_decode_pkg::EXC_ILLEGAL;
        end
    end

endmodule

// File: int_op_decoder.sv
`timescale 1ns/1ps

module int_op_decoder (
    input  la32_decode_pkg::insn_t     insn,
    input  la32_decode_pkg::iq_class_t iq_class,
    output la32_decode_pkg::alu0_op_t  alu0_op,
    output la32_decode_pkg::alu1_op_t  alu1_op,
    output la32_decode_pkg::alu0_imm_t alu0_imm
);

    always_comb begin
        alu0_op  = '0;
        alu0_imm = '0;
        if (iq_class == la32_decode_pkg::IQ_ALU0) begin
            alu0_imm = insn[28] ? insn[24:5] : {8'd0, insn[21:10]};   // LU12I.W takes si20
            if (insn[28]) begin
                alu0_op = la32_decode_pkg::ALU0_LU12I;
            end else if (insn[25]) begin
                case (insn[24:22])
                    3'b000:  alu0_op = la32_decode_pkg::ALU0_SLTI;
                    3'b001:  alu0_op = la32_decode_pkg::ALU0_SLTUI;
                    3'b010:  alu0_op = la32_decode_pkg::ALU0_ADDI;
                    3'b101:  alu0_op = la32_decode_pkg::ALU0_ANDI;
                    3'b110:  alu0_op = la32_decode_pkg::ALU0_ORI;
                    default: alu0_op = la32_decode_pkg::ALU0_XORI;
                endcase
            end else if (insn[22]) begin
                case (insn[19:18])
                    2'b00:   alu0_op = la32_decode_pkg::ALU0_SLLI;
                    2'b01:   alu0_op = la32_decode_pkg::ALU0_SRLI;
                    default: alu0_op = la32_decode_pkg::ALU0_SRAI;
                endcase
            end else if (insn[20]) begin
                case (insn[19:15])
                    5'b00000: alu0_op = la32_decode_pkg::ALU0_ADD;
                    5'b00010: alu0_op = la32_decode_pkg::ALU0_SUB;
                    5'b00100: alu0_op = la32_decode_pkg::ALU0_SLT;
                    5'b00101: alu0_op = la32_decode_pkg::ALU0_SLTU;
                    5'b01000: alu0_op = la32_decode_pkg::ALU0_NOR;
                    5'b01001: alu0_op = la32_decode_pkg::ALU0_AND;
                    5'b01010: alu0_op = la32_decode_pkg::ALU0_OR;
                    5'b01011: alu0_op = la32_decode_pkg::ALU0_XOR;
                    5'b01110: alu0_op = la32_decode_pkg::ALU0_SLL;
                    5'b01111: alu0_op = la32_decode_pkg::ALU0_SRL;
                    default:  alu0_op = la32_decode_pkg::ALU0_SRA;
                endcase
            end else if (insn[10]) begin
                alu0_op = la32_decode_pkg::ALU0_RDCNTVH;
            end else if (insn[4:0] == 5'd0) begin
                alu0_op = la32_decode_pkg::ALU0_RDCNTID;
            end else begin
                alu0_op = la32_decode_pkg::ALU0_RDCNTVL;
            end
        end
    end

    always_comb begin
        alu1_op = '0;
        if (iq_class == la32_decode_pkg::IQ_ALU1) begin
            case ({insn[21], insn[16:15]})
                3'b100:  alu1_op = la32_decode_pkg::ALU1_DIV;
                3'b101:  alu1_op = la32_decode_pkg::ALU1_MOD;
                3'b110:  alu1_op = la32_decode_pkg::ALU1_DIVU;
                3'b111:  alu1_op = la32_decode_pkg::ALU1_MODU;
                3'b000:  alu1_op = la32_decode_pkg::ALU1_MUL;
                3'b001:  alu1_op = la32_decode_pkg::ALU1_MULH;
                default: alu1_op = la32_decode_pkg::ALU1_MULHU;
            endcase
        end
    end

endmodule

// File: branch_decoder.sv
`timescale 1ns/1ps

module branch_decoder (
    input  la32_decode_pkg::insn_t     insn,
    input  la32_decode_pkg::iq_class_t iq_class,
    output la32_decode_pkg::bru_op_t   bru_op,
    output la32_decode_pkg::bru_imm_t  bru_imm
);

    always_comb begin
        bru_op  = '0;
        bru_imm = '0;
        if (iq_class == la32_decode_pkg::IQ_BRU) begin
            if (!insn[30]) begin
                bru_op  = la32_decode_pkg::BRU_PCADDU12I;
                bru_imm = {6'd0, insn[24:5]};
            end else begin
                case (insn[29:26])
                    4'b0011: bru_op = la32_decode_pkg::BRU_JIRL;
                    4'b0100: bru_op = la32_decode_pkg::BRU_B;
                    4'b0101: bru_op = la32_decode_pkg::BRU_BL;
                    4'b0110: bru_op = la32_decode_pkg::BRU_BEQ;
                    4'b0111: bru_op = la32_decode_pkg::BRU_BNE;
                    4'b1000: bru_op = la32_decode_pkg::BRU_BLT;
                    4'b1001: bru_op = la32_decode_pkg::BRU_BGE;
                    4'b1010: bru_op = la32_decode_pkg::BRU_BLTU;
                    4'b1011: bru_op = la32_decode_pkg::BRU_BGEU;
                    default: bru_op = '0;
                endcase
                if (insn[29:27] == 3'b010)
                    bru_imm = {insn[9:0], insn[25:10]};     // B/BL offs26
                else
                    bru_imm = {10'd0, insn[25:10]};
            end
        end
    end

endmodule

// File: operand_decoder.sv
`timescale 1ns/1ps

module operand_decoder (
    input  la32_decode_pkg::insn_t     insn,
    input  la32_decode_pkg::iq_class_t iq_class,
    output logic                       dst_en,
    output la32_decode_pkg::reg_idx_t  dst_reg,
    output logic                       src1_en,
    output la32_decode_pkg::reg_idx_t  src1_reg,
    output logic                       src2_en,
    output la32_decode_pkg::reg_idx_t  src2_reg
);

    logic is_bl;
    logic is_jirl;
    logic is_cond_br;
    logic alu0_no_src;
    logic bru_no_src;

    assign is_bl       = (insn[31:26] == 6'b010101);
    assign is_jirl     = (insn[31:26] == 6'b010011);
    assign is_cond_br  = (insn[31:26] >= 6'b010110) && (insn[31:26] <= 6'b011011);
    assign alu0_no_src = (insn[31:15] == 17'd0) || (insn[31:25] == 7'b0001010);  // RDCNT LU12I.W
    assign bru_no_src  = (insn[31:27] == 5'b01010) || (insn[31:25] == 7'b0001110); // B BL PCADDU12I

    assign dst_reg  = is_bl ? la32_decode_pkg::LINK_REG : insn[4:0];
    assign src1_reg = insn[9:5];
    assign src2_reg = (iq_class == la32_decode_pkg::IQ_BRU) ? insn[4:0] : insn[14:10];

    always_comb begin
        dst_en  = 1'b0;
        src1_en = 1'b0;
        src2_en = 1'b0;
        case (iq_class)
            la32_decode_pkg::IQ_ALU0: begin
                dst_en  = 1'b1;
                src1_en = !alu0_no_src;
                src2_en = !alu0_no_src && !insn[25] && !insn[22];  // Reg-reg forms only
            end
            la32_decode_pkg::IQ_ALU1: begin
                dst_en  = 1'b1;
                src1_en = 1'b1;
                src2_en = 1'b1;
            end
            la32_decode_pkg::IQ_BRU: begin
                dst_en  = is_jirl || is_bl;
                src1_en = !bru_no_src;
                src2_en = is_cond_br;
            end
            default: ;
        endcase
    end

endmodule

// File: decode_stage_reg.sv
`timescale 1ns/1ps

module decode_stage_reg (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush,
    input  logic                          in_valid,
    output logic                          in_ready,
    output logic                          out_valid,
    input  logic                          out_ready,
    input  la32_decode_pkg::pc_t          pc,
    input  la32_decode_pkg::iq_class_t    iq_class,
    input  la32_decode_pkg::alu0_op_t     alu0_op,
    input  la32_decode_pkg::alu1_op_t     alu1_op,
    input  la32_decode_pkg::bru_op_t      bru_op,
    input  la32_decode_pkg::alu0_imm_t    alu0_imm,
    input  la32_decode_pkg::bru_imm_t     bru_imm,
    input  logic                          dst_en,
    input  la32_decode_pkg::reg_idx_t     dst_reg,
    input  logic                          src1_en,
    input  la32_decode_pkg::reg_idx_t     src1_reg,
    input  logic                          src2_en,
    input  la32_decode_pkg::reg_idx_t     src2_reg,
    input  la32_decode_pkg::exc_cause_t   exc_cause,
    input  la32_decode_pkg::exc_code_t    exc_code,
    output la32_decode_pkg::pc_t          out_pc,
    output la32_decode_pkg::iq_class_t    out_iq_class,
    output la32_decode_pkg::alu0_op_t     out_alu0_op,
    output la32_decode_pkg::alu1_op_t     out_alu1_op,
    output la32_decode_pkg::bru_op_t      out_bru_op,
    output la32_decode_pkg::alu0_imm_t    out_alu0_imm,
    output la32_decode_pkg::bru_imm_t     out_bru_imm,
    output logic                          out_dst_en,
    output la32_decode_pkg::reg_idx_t     out_dst_reg,
    output logic                          out_src1_en,
    output la32_decode_pkg::reg_idx_t     out_src1_reg,
    output logic                          out_src2_en,
    output la32_decode_pkg::reg_idx_t     out_src2_reg,
    output la32_decode_pkg::exc_cause_t   out_exc_cause,
    output la32_decode_pkg::exc_code_t    out_exc_code
);

    localparam int ITEM_W = $bits(la32_decode_pkg::pc_t) + $bits(la32_decode_pkg::iq_class_t)
        + $bits(la32_decode_pkg::alu0_op_t) + $bits(la32_decode_pkg::alu1_op_t)
        + $bits(la32_decode_pkg::bru_op_t) + $bits(la32_decode_pkg::alu0_imm_t)
        + $bits(la32_decode_pkg::bru_imm_t) + 3 * (1 + $bits(la32_decode_pkg::reg_idx_t))
        + $bits(la32_decode_pkg::exc_cause_t) + $bits(la32_decode_pkg::exc_code_t);

    logic [ITEM_W-1:0] item_d;
    logic [ITEM_W-1:0] item_q;
    logic              load;

    assign in_ready = !out_valid || out_ready;  // Free slot or draining this cycle
    assign load     = in_valid && in_ready;

    assign item_d = {pc, iq_class, alu0_op, alu1_op, bru_op, alu0_imm, bru_imm,
                     dst_en, dst_reg, src1_en, src1_reg, src2_en, src2_reg,
                     exc_cause, exc_code};

    assign {out_pc, out_iq_class, out_alu0_op, out_alu1_op, out_bru_op, out_alu0_imm,
            out_bru_imm, out_dst_en, out_dst_reg, out_src1_en, out_src1_reg,
            out_src2_en, out_src2_reg, out_exc_cause, out_exc_code} = item_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            item_q    <= '0;
        end else if (flush) begin
            out_valid <= 1'b0;    // Offered input is dropped too
            item_q    <= '0;
        end else if (load) begin
            out_valid <= 1'b1;
            item_q    <= item_d;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

endmodule

// File: la32_decode.sv
`timescale 1ns/1ps

module la32_decode (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  la32_decode_pkg::insn_t      insn,
    input  la32_decode_pkg::pc_t        pc,
    input  logic                        flush,
    output logic                        out_valid,
    input  logic                        out_ready,
    output la32_decode_pkg::pc_t        out_pc,
    output la32_decode_pkg::iq_class_t  iq_class,
    output la32_decode_pkg::alu0_op_t   alu0_op,
    output la32_decode_pkg::alu1_op_t   alu1_op,
    output la32_decode_pkg::bru_op_t    bru_op,
    output la32_decode_pkg::alu0_imm_t  alu0_imm,
    output la32_decode_pkg::bru_imm_t   bru_imm,
    output logic                        dst_en,
    output la32_decode_pkg::reg_idx_t   dst_reg,
    output logic                        src1_en,
    output la32_decode_pkg::reg_idx_t   src1_reg,
    output logic                        src2_en,
    output la32_decode_pkg::reg_idx_t   src2_reg,
    output la32_decode_pkg::exc_cause_t exc_cause,
    output la32_decode_pkg::exc_code_t  exc_code
);

    la32_decode_pkg::iq_class_t  dec_iq_class;
    la32_decode_pkg::alu0_op_t   dec_alu0_op;
    la32_decode_pkg::alu1_op_t   dec_alu1_op;
    la32_decode_pkg::bru_op_t    dec_bru_op;
    la32_decode_pkg::alu0_imm_t  dec_alu0_imm;
    la32_decode_pkg::bru_imm_t   dec_bru_imm;
    logic                        dec_dst_en;
    la32_decode_pkg::reg_idx_t   dec_dst_reg;
    logic                        dec_src1_en;
    la32_decode_pkg::reg_idx_t   dec_src1_reg;
    logic                        dec_src2_en;
    la32_decode_pkg::reg_idx_t   dec_src2_reg;
    la32_decode_pkg::exc_cause_t dec_exc_cause;
    la32_decode_pkg::exc_code_t  dec_exc_code;

    insn_classifier insn_classifier_i (
        .insn      (insn),
        .iq_class  (dec_iq_class),
        .exc_cause (dec_exc_cause),
        .exc_code  (dec_exc_code)
    );

    int_op_decoder int_op_decoder_i (
        .insn      (insn),
        .iq_class  (dec_iq_class),
        .alu0_op   (dec_alu0_op),
        .alu1_op   (dec_alu1_op),
        .alu0_imm  (dec_alu0_imm)
    );

    branch_decoder branch_decoder_i (
        .insn      (insn),
        .iq_class  (dec_iq_class),
        .bru_op    (dec_bru_op),
        .bru_imm   (dec_bru_imm)
    );

    operand_decoder operand_decoder_i (
        .insn      (insn),
        .iq_class  (dec_iq_class),
        .dst_en    (dec_dst_en),
        .dst_reg   (dec_dst_reg),
        .src1_en   (dec_src1_en),
        .src1_reg  (dec_src1_reg),
        .src2_en   (dec_src2_en),
        .src2_reg  (dec_src2_reg)
    );

    decode_stage_reg decode_stage_reg_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .pc            (pc),
        .iq_class      (dec_iq_class),
        .alu0_op       (dec_alu0_op),
        .alu1_op       (dec_alu1_op),
        .bru_op        (dec_bru_op),
        .alu0_imm      (dec_alu0_imm),
        .bru_imm       (dec_bru_imm),
        .dst_en        (dec_dst_en),
        .dst_reg       (dec_dst_reg),
        .src1_en       (dec_src1_en),
        .src1_reg      (dec_src1_reg),
        .src2_en       (dec_src2_en),
        .src2_reg      (dec_src2_reg),
        .exc_cause     (dec_exc_cause),
        .exc_code      (dec_exc_code),
        .out_pc        (out_pc),
        .out_iq_class  (iq_class),
        .out_alu0_op   (alu0_op),
        .out_alu1_op   (alu1_op),
        .out_bru_op    (bru_op),
        .out_alu0_imm  (alu0_imm),
        .out_bru_imm   (bru_imm),
        .out_dst_en    (dst_en),
        .out_dst_reg   (dst_reg),
        .out_src1_en   (src1_en),
        .out_src1_reg  (src1_reg),
        .out_src2_en   (src2_en),
        .out_src2_reg  (src2_reg),
        .out_exc_cause (exc_cause),
        .out_exc_code  (exc_code)
    );

endmodule

// File: la32_decode_properties.sv
`timescale 1ns/1ps

module la32_decode_properties (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        flush,
    input logic                        in_ready,
    input logic                        out_valid,
    input logic                        out_ready,
    input la32_decode_pkg::pc_t        out_pc,
    input la32_decode_pkg::iq_class_t  iq_class,
    input la32_decode_pkg::alu0_op_t   alu0_op,
    input la32_decode_pkg::alu1_op_t   alu1_op,
    input la32_decode_pkg::bru_op_t    bru_op,
    input la32_decode_pkg::alu0_imm_t  alu0_imm,
    input la32_decode_pkg::bru_imm_t   bru_imm,
    input logic                        dst_en,
    input la32_decode_pkg::reg_idx_t   dst_reg,
    input logic                        src1_en,
    input la32_decode_pkg::reg_idx_t   src1_reg,
    input logic                        src2_en,
    input la32_decode_pkg::reg_idx_t   src2_reg,
    input la32_decode_pkg::exc_cause_t exc_cause,
    input la32_decode_pkg::exc_code_t  exc_code
);

    reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high after reset");

    stall_holds_outputs: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready && !flush) |=> out_valid && $stable(out_pc)
            && $stable(iq_class) && $stable(alu0_op) && $stable(alu1_op) && $stable(bru_op)
            && $stable(alu0_imm) && $stable(bru_imm) && $stable(dst_en) && $stable(dst_reg)
            && $stable(src1_en) && $stable(src1_reg) && $stable(src2_en) && $stable(src2_reg)
            && $stable(exc_cause) && $stable(exc_code))
        else $error("outputs changed during a stall");

    flush_clears_valid: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !out_valid)
        else $error("out_valid high after a flush");

    ready_rule: assert property (@(posedge clk) disable iff (!rst_n)
        in_ready == (!out_valid || out_ready))
        else $error("in_ready does not follow out_valid and out_ready");

endmodule

bind la32_decode la32_decode_properties la32_decode_properties_i (.*);

// File: tb_la32_decode.sv
`timescale 1ns/1ps

module tb_la32_decode;

    typedef struct packed {
        la32_decode_pkg::insn_t      insn;
        la32_decode_pkg::pc_t        pc;
        la32_decode_pkg::iq_class_t  cls;
        la32_decode_pkg::alu0_op_t   a0_op;
        la32_decode_pkg::alu1_op_t   a1_op;
        la32_decode_pkg::bru_op_t    b_op;
        la32_decode_pkg::alu0_imm_t  a0_imm;
        la32_decode_pkg::bru_imm_t   b_imm;
        logic                        de;
        la32_decode_pkg::reg_idx_t   dr;
        logic                        s1e;
        la32_decode_pkg::reg_idx_t   s1r;
        logic                        s2e;
        la32_decode_pkg::reg_idx_t   s2r;
        la32_decode_pkg::exc_cause_t ec;
        la32_decode_pkg::exc_code_t  ecode;
    } item_t;

    logic clk;
    logic rst_n;
    logic in_valid;
    logic in_ready;
    la32_decode_pkg::insn_t insn;
    la32_decode_pkg::pc_t   pc;
    logic flush;
    logic out_valid;
    logic out_ready;
    la32_decode_pkg::pc_t        out_pc;
    la32_decode_pkg::iq_class_t  iq_class;
    la32_decode_pkg::alu0_op_t   alu0_op;
    la32_decode_pkg::alu1_op_t   alu1_op;
    la32_decode_pkg::bru_op_t    bru_op;
    la32_decode_pkg::alu0_imm_t  alu0_imm;
    la32_decode_pkg::bru_imm_t   bru_imm;
    logic                        dst_en;
    la32_decode_pkg::reg_idx_t   dst_reg;
    logic                        src1_en;
    la32_decode_pkg::reg_idx_t   src1_reg;
    logic                        src2_en;
    la32_decode_pkg::reg_idx_t   src2_reg;
    la32_decode_pkg::exc_cause_t exc_cause;
    la32_decode_pkg::exc_code_t  exc_code;

    item_t exp_q[$];
    int    mismatch_cnt = 0;
    int    other_cnt = 0;
    logic  random_ready = 1'b0;
    logic  hold_ready = 1'b1;
    la32_decode_pkg::pc_t next_pc = 32'h1c00_0000;

    la32_decode la32_decode_i (.*);

    always #4 clk = ~clk;

    always @(negedge clk) begin
        out_ready <= random_ready ? 1'($urandom_range(0, 1)) : hold_ready;
    end

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out waiting for %s at %0t", what, $time);
        other_cnt++;
        finish_run();
    endtask

    task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
            mismatch_cnt++;
        end
    endtask

    // Builds an instruction of the given kind and its expected decode
    function automatic item_t make_item(input int kind);
        item_t it;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [11:0] i12;
        logic [19:0] si20;
        logic [25:0] off;
        rd   = 5'($urandom);
        rj   = 5'($urandom);
        rk   = 5'($urandom);
        i12  = 12'($urandom);
        si20 = 20'($urandom);
        off  = 26'($urandom);
        it = '0;
        it.cls = la32_decode_pkg::IQ_NONE;
        case (kind)
            0:  it.insn = 32'h0010_0000 | 32'({rk, rj, rd});
            1:  it.insn = 32'h0011_0000 | 32'({rk, rj, rd});
            2:  it.insn = 32'h0280_0000 | 32'({i12, rj, rd});
            3:  it.insn = 32'h0380_0000 | 32'({i12, rj, rd});
            4:  it.insn = 32'h0040_8000 | 32'({rk, rj, rd});
            5:  it.insn = 32'h1400_0000 | 32'({si20, rd});
            6:  it.insn = 32'h0000_6000 | 32'((rd == 0) ? 5'd1 : rd);    // rd zero is RDCNTID
            7:  it.insn = 32'h001c_0000 | 32'({rk, rj, rd});
            8:  it.insn = 32'h001d_0000 | 32'({rk, rj, rd});
            9:  it.insn = 32'h0020_0000 | 32'({rk, rj, rd});
            10: it.insn = 32'h0021_8000 | 32'({rk, rj, rd});
            11: it.insn = 32'h5000_0000 | 32'({off[15:0], off[25:16]});
            12: it.insn = 32'h5400_0000 | 32'({off[15:0], off[25:16]});
            13: it.insn = 32'h4c00_0000 | 32'({off[15:0], rj, rd});
            14: it.insn = 32'h5800_0000 | 32'({off[15:0], rj, rd});
            15: it.insn = 32'h6c00_0000 | 32'({off[15:0], rj, rd});
            16: it.insn = 32'h1c00_0000 | 32'({si20, rd});
            17: it.insn = 32'h002a_0000 | 32'({rk, rj, rd});
            18: it.insn = 32'h002b_0000 | 32'({rk, rj, rd});
            default: it.insn = 32'hffff_ffff;
        endcase
        if (kind <= 6) begin
            it.cls = la32_decode_pkg::IQ_ALU0;
            it.de  = 1'b1;
            it.s1e = (kind != 5) && (kind != 6);
            it.s2e = (kind <= 1);
            it.a0_imm = (kind == 5) ? si20 : {8'd0, it.insn[21:10]};
            case (kind)
                0: it.a0_op = la32_decode_pkg::ALU0_ADD;
                1: it.a0_op = la32_decode_pkg::ALU0_SUB;
                2: it.a0_op = la32_decode_pkg::ALU0_ADDI;
                3: it.a0_op = la32_decode_pkg::ALU0_ORI;
                4: it.a0_op = la32_decode_pkg::ALU0_SLLI;
                5: it.a0_op = la32_decode_pkg::ALU0_LU12I;
                default: it.a0_op = la32_decode_pkg::ALU0_RDCNTVL;
            endcase
        end else if (kind <= 10) begin
            it.cls = la32_decode_pkg::IQ_ALU1;
            {it.de, it.s1e, it.s2e} = 3'b111;
            it.a1_op = (kind == 7) ? la32_decode_pkg::ALU1_MUL
                     : (kind == 8) ? la32_decode_pkg::ALU1_MULHU
                     : (kind == 9) ? la32_decode_pkg::ALU1_DIV : la32_decode_pkg::ALU1_MODU;
        end else if (kind <= 16) begin
            it.cls = la32_decode_pkg::IQ_BRU;
            it.de  = (kind == 12) || (kind == 13);
            it.s1e = (kind == 13) || (kind == 14) || (kind == 15);
            it.s2e = (kind == 14) || (kind == 15);
            it.b_op = (kind == 11) ? la32_decode_pkg::BRU_B
                    : (kind == 12) ? la32_decode_pkg::BRU_BL
                    : (kind == 13) ? la32_decode_pkg::BRU_JIRL
                    : (kind == 14) ? la32_decode_pkg::BRU_BEQ
                    : (kind == 15) ? la32_decode_pkg::BRU_BGEU : la32_decode_pkg::BRU_PCADDU12I;
            if (kind == 16)
                it.b_imm = {6'd0, si20};
            else if (kind <= 12)
                it.b_imm = off;
            else
                it.b_imm = {10'd0, off[15:0]};
        end else begin
            it.ec = (kind == 17) ? la32_decode_pkg::EXC_BREAK
                  : (kind == 18) ? la32_decode_pkg::EXC_SYSCALL : la32_decode_pkg::EXC_ILLEGAL;
            it.ecode = (kind == 19) ? 15'd0 : it.insn[14:0];
        end
        it.dr  = (kind == 12) ? la32_decode_pkg::LINK_REG : it.insn[4:0];
        it.s1r = it.insn[9:5];
        it.s2r = (it.cls == la32_decode_pkg::IQ_BRU) ? it.insn[4:0] : it.insn[14:10];
        it.pc  = next_pc;
        next_pc = next_pc + 4;
        return it;
    endfunction

    // Called on a falling edge, returns on a falling edge
    task automatic send(input item_t it);
        int waited;
        logic acc;
        in_valid = 1'b1;
        insn     = it.insn;
        pc       = it.pc;
        waited   = 0;
        acc      = 1'b0;
        while (!acc) begin
            @(posedge clk);
            if (in_ready) begin
                exp_q.push_back(it);
                acc = 1'b1;
            end else begin
                waited++;
                if (waited > 100)
                    timeout_fail("in_ready");
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > 1000)
                timeout_fail("outstanding items to leave the decoder");
        end
        @(negedge clk);
    endtask

    // Scoreboard on output transfers
    always @(posedge clk) begin
        item_t e;
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Output item at %0t with pc %h was never sent", $time, out_pc);
                other_cnt++;
            end else begin
                e = exp_q.pop_front();
                check_field("out_pc", out_pc, e.pc);
                check_field("iq_class", 32'(iq_class), 32'(e.cls));
                check_field("alu0_op", 32'(alu0_op), 32'(e.a0_op));
                check_field("alu1_op", 32'(alu1_op), 32'(e.a1_op));
                check_field("bru_op", 32'(bru_op), 32'(e.b_op));
                check_field("alu0_imm", 32'(alu0_imm), 32'(e.a0_imm));
                check_field("bru_imm", 32'(bru_imm), 32'(e.b_imm));
                check_field("dst_en", 32'(dst_en), 32'(e.de));
                check_field("dst_reg", 32'(dst_reg), 32'(e.dr));
                check_field("src1_en", 32'(src1_en), 32'(e.s1e));
                check_field("src1_reg", 32'(src1_reg), 32'(e.s1r));
                check_field("src2_en", 32'(src2_en), 32'(e.s2e));
                check_field("src2_reg", 32'(src2_reg), 32'(e.s2r));
                check_field("exc_cause", 32'(exc_cause), 32'(e.ec));
                check_field("exc_code", 32'(exc_code), 32'(e.ecode));
            end
        end
    end

    initial begin
        void'($urandom(32'h21a3));
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        insn = '0;
        pc = '0;
        flush = 1'b0;
        out_ready = 1'b1;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (int k = 0; k < 20; k++)    // Every kind once, full rate
            send(make_item(k));
        drain();

        random_ready = 1'b1;    // Mixed stream under back-pressure
        for (int n = 0; n < 200; n++)
            send(make_item($urandom_range(0, 19)));
        random_ready = 1'b0;
        drain();

        hold_ready = 1'b0;
        @(negedge clk);
        send(make_item(0));
        @(negedge clk);
        flush = 1'b1;
        @(posedge clk);
        void'(exp_q.pop_back());    // Flushed item never leaves
        @(negedge clk);
        flush = 1'b0;
        assert (!out_valid) else begin
            $display("out_valid still high after a flush at %0t", $time);
            other_cnt++;
        end
        hold_ready = 1'b1;
        send(make_item(12));
        drain();
        finish_run();
    end

endmodule

// File: la32_decode.f
la32_decode_pkg.sv
insn_classifier.sv
int_op_decoder.sv
branch_decoder.sv
operand_decoder.sv
decode_stage_reg.sv
la32_decode.sv
la32_decode_properties.sv
tb_la32_decode.sv

// File: Makefile
TOP = tb_la32_decode

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f la32_decode.f --top-module $(TOP)

sim:
	verilator --binary --assert -f la32_decode.f --top-module $(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
